//--- hw/tts_cfg.svh
// Widths, depths and latencies of the time-tagging capture buffer.
// Include this wherever a size or a pipeline depth is needed.
`ifndef TTS_CFG_SVH
`define TTS_CFG_SVH

// payload widths in bits
`define TTS_SAMPLE_WIDTH 64
`define TTS_TSTAMP_WIDTH 32

// readout bus, a multiple of both payload widths
`define TTS_BUS_WIDTH 128

// buffer depths in words
`define TTS_SAMPLE_DEPTH 64
`define TTS_TSTAMP_DEPTH 32

// memory read pipeline depth in cycles
`define TTS_READ_LATENCY 2

// cycles from discriminator reset to the first valid discriminator output
`define TTS_DISC_LATENCY 4

`endif

//--- hw/tts_pkg.sv
// Shared types for the time-tagging capture buffer.
// Modules take them with a wildcard import in their header.
`include "tts_cfg.svh"

package tts_pkg;

  ////////////////////////////////////////////////////////////
  // payload and bus words
  ////////////////////////////////////////////////////////////

  typedef logic [`TTS_SAMPLE_WIDTH-1:0] sample_t;
  typedef logic [`TTS_TSTAMP_WIDTH-1:0] tstamp_t;
  typedef logic [`TTS_BUS_WIDTH-1:0] bus_word_t;

  ////////////////////////////////////////////////////////////
  // control encodings
  ////////////////////////////////////////////////////////////

  // capture buffer states
  typedef enum logic [2:0] {
    IDLE    = 3'd0,
    ARMED   = 3'd1,
    CAPTURE = 3'd2,
    HOLD    = 3'd3,
    READOUT = 3'd4
  } capture_state_t;

  // which packed stream owns the readout bus
  typedef enum logic {
    TIMESTAMP = 1'b0,
    SAMPLE    = 1'b1
  } stream_sel_t;

endpackage

//--- hw/capture_control.sv
// Turns the arm/start/stop pulses into buffer controls and the discriminator reset.
// Start waits out the discriminator latency before the buffers begin to capture.
`timescale 1ns/1ps
`include "tts_cfg.svh"

module capture_control (
  input  logic       ps_clk,
  input  logic       ps_reset,
  input  logic       arm,
  input  logic       start,
  input  logic       stop,
  input  logic       digital_trigger,
  input  logic [1:0] buffers_ready,
  output logic       arm_pulse,
  output logic       hw_start,
  output logic       stop_pulse,
  output logic       discriminator_reset
);

  localparam int DL = `TTS_DISC_LATENCY;

  logic start_stop_ok;
  logic [DL-1:0] start_pipe;

  // no start or stop while either buffer holds or reads out
  assign start_stop_ok = &buffers_ready;

  ////////////////////////////////////////////////////////////
  // pulse registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge ps_clk) begin
    if (ps_reset) begin
      arm_pulse           <= 1'b0;
      stop_pulse          <= 1'b0;
      discriminator_reset <= 1'b0;
    end else begin
      arm_pulse           <= arm;
      stop_pulse          <= stop && start_stop_ok;
      discriminator_reset <= start && start_stop_ok;
    end
  end

  // start delay line behind the discriminator reset
  always_ff @(posedge ps_clk) begin
    if (ps_reset) begin
      start_pipe <= '0;
    end else begin
      start_pipe[0] <= discriminator_reset;
      for (int i = 1; i < DL; i++) begin
        start_pipe[i] <= start_pipe[i-1];
      end
    end
  end

  // external trigger bypasses the delay
  assign hw_start = start_pipe[DL-1] | digital_trigger;

endmodule

//--- hw/capture_buffer.sv
// One capture memory: arm/start/stop capture, then a pipelined readout stream.
// Instantiated once per payload type; depth and payload come in as parameters.
`timescale 1ns/1ps
`include "tts_cfg.svh"

module capture_buffer
  import tts_pkg::*;
#(
  parameter type payload_t = sample_t,
  parameter int  DEPTH     = `TTS_SAMPLE_DEPTH
) (
  input  logic                   ps_clk,
  input  logic                   ps_reset,
  input  payload_t               in_data,
  input  logic                   in_valid,
  input  logic                   arm_pulse,
  input  logic                   hw_start,
  input  logic                   hw_stop,
  input  logic                   capture_sw_reset,
  input  logic                   readout_sw_reset,
  input  logic                   readout_start,
  output logic                   capture_ready,
  output logic                   full,
  output logic [$clog2(DEPTH):0] write_depth,
  output payload_t               out_data,
  output logic                   out_valid,
  output logic                   out_last,
  input  logic                   out_ready
);

  localparam int AW     = $clog2(DEPTH);
  localparam int RL     = `TTS_READ_LATENCY;
  localparam int QDEPTH = RL + 2;
  localparam int QW     = $clog2(QDEPTH);
  localparam int CW     = $clog2(QDEPTH + 1);

  capture_state_t    state;
  payload_t          mem [DEPTH];
  logic              wr_en;
  logic [AW:0]       rd_issued;
  logic [AW:0]       rd_total;
  logic              rd_issue;
  logic              rd_issue_last;
  payload_t          rd_data [RL];
  logic [RL-1:0]     rd_valid;
  logic [RL-1:0]     rd_last;
  payload_t          q_data [QDEPTH];
  logic [QDEPTH-1:0] q_last;
  logic [QW-1:0]     q_wr_ptr;
  logic [QW-1:0]     q_rd_ptr;
  logic [CW-1:0]     q_count;
  logic [CW-1:0]     pending;
  logic              q_push;
  logic              q_pop;

  ////////////////////////////////////////////////////////////
  // capture side
  ////////////////////////////////////////////////////////////

  assign wr_en         = (state == CAPTURE) && in_valid;
  assign capture_ready = (state != HOLD) && (state != READOUT);
  assign full          = (write_depth == (AW + 1)'(DEPTH));

  always_ff @(posedge ps_clk) begin
    if (ps_reset || capture_sw_reset) begin
      state       <= IDLE;
      write_depth <= '0;
    end else begin
      if (wr_en) begin
        write_depth <= write_depth + 1'b1;
      end
      unique case (state)
        IDLE: begin
          if (arm_pulse) begin
            state       <= ARMED;
            write_depth <= '0;
          end
        end
        ARMED: if (hw_start) state <= CAPTURE;
        // last write into the final slot also ends the capture
        CAPTURE: begin
          if (hw_stop || (wr_en && write_depth == (AW + 1)'(DEPTH - 1))) begin
            state <= HOLD;
          end
        end
        HOLD: if (readout_start) state <= READOUT;
        READOUT: begin
          if (readout_sw_reset) begin
            state <= HOLD;
          end else if (q_pop && out_last) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // readout side
  ////////////////////////////////////////////////////////////

  // an empty buffer still sends one word
  assign rd_total      = (write_depth == '0) ? (AW + 1)'(1) : write_depth;
  assign rd_issue_last = (rd_issued == rd_total - 1'b1);
  // pending counts queued words plus reads in flight
  assign rd_issue      = (state == READOUT) && (rd_issued < rd_total) &&
                         (pending < CW'(QDEPTH));
  assign q_push        = rd_valid[RL-1];
  assign q_pop         = out_valid && out_ready;

  assign out_valid = (q_count != '0);
  assign out_data  = q_data[q_rd_ptr];
  assign out_last  = q_last[q_rd_ptr];

  always_ff @(posedge ps_clk) begin
    if (ps_reset || state != READOUT || capture_sw_reset || readout_sw_reset) begin
      rd_issued <= '0;
      rd_valid  <= '0;
      rd_last   <= '0;
      q_wr_ptr  <= '0;
      q_rd_ptr  <= '0;
      q_count   <= '0;
      pending   <= '0;
    end else begin
      if (rd_issue) begin
        rd_issued <= rd_issued + 1'b1;
      end
      rd_valid[0] <= rd_issue;
      rd_last[0]  <= rd_issue && rd_issue_last;
      for (int i = 1; i < RL; i++) begin
        rd_valid[i] <= rd_valid[i-1];
        rd_last[i]  <= rd_last[i-1];
      end
      if (q_push) begin
        q_wr_ptr <= (q_wr_ptr == QW'(QDEPTH - 1)) ? '0 : q_wr_ptr + 1'b1;
      end
      if (q_pop) begin
        q_rd_ptr <= (q_rd_ptr == QW'(QDEPTH - 1)) ? '0 : q_rd_ptr + 1'b1;
      end
      q_count <= q_count + CW'(q_push) - CW'(q_pop);
      pending <= pending + CW'(rd_issue) - CW'(q_pop);
    end
  end

  // memory, read pipeline and queue storage
  always_ff @(posedge ps_clk) begin
    if (wr_en) begin
      mem[write_depth[AW-1:0]] <= in_data;
    end
    rd_data[0] <= (write_depth == '0) ? '0 : mem[rd_issued[AW-1:0]];
    for (int i = 1; i < RL; i++) begin
      rd_data[i] <= rd_data[i-1];
    end
    if (q_push) begin
      q_data[q_wr_ptr] <= rd_data[RL-1];
      q_last[q_wr_ptr] <= rd_last[RL-1];
    end
  end

  // capture must end on the final slot, so no write goes past it
  a_write_in_range: assert property (@(posedge ps_clk) disable iff (ps_reset)
    wr_en |-> (write_depth < (AW + 1)'(DEPTH)));

  // a stalled word stays put until taken
  a_out_stable: assert property (@(posedge ps_clk)
    disable iff (ps_reset || capture_sw_reset || readout_sw_reset)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data) && $stable(out_last)));

endmodule

//--- hw/width_packer.sv
// Packs narrow readout words into readout bus words, lowest slot first.
// A bus word goes out when full or when its last narrow word carried last.
`timescale 1ns/1ps
`include "tts_cfg.svh"

module width_packer
  import tts_pkg::*;
#(
  parameter int IN_WIDTH = `TTS_TSTAMP_WIDTH
) (
  input  logic                ps_clk,
  input  logic                ps_reset,
  input  logic                flush,
  input  logic [IN_WIDTH-1:0] in_data,
  input  logic                in_valid,
  input  logic                in_last,
  output logic                in_ready,
  output bus_word_t           out_data,
  output logic                out_valid,
  output logic                out_last,
  input  logic                out_ready
);

  localparam int RATIO = `TTS_BUS_WIDTH / IN_WIDTH;
  localparam int SW    = (RATIO > 1) ? $clog2(RATIO) : 1;

  bus_word_t acc;
  bus_word_t acc_next;
  logic [SW-1:0] slot;
  logic in_ok;
  logic word_done;

  // take input whenever the output register is free or draining
  assign in_ready  = !out_valid || out_ready;
  assign in_ok     = in_valid && in_ready;
  assign acc_next  = acc | (bus_word_t'(in_data) << (slot * IN_WIDTH));
  assign word_done = in_last || (slot == SW'(RATIO - 1));

  always_ff @(posedge ps_clk) begin
    if (ps_reset || flush) begin
      acc       <= '0;
      slot      <= '0;
      out_valid <= 1'b0;
      out_last  <= 1'b0;
    end else begin
      if (out_valid && out_ready) begin
        out_valid <= 1'b0;
      end
      if (in_ok) begin
        if (word_done) begin
          // slots above the last word stay zero
          acc       <= '0;
          slot      <= '0;
          out_valid <= 1'b1;
          out_last  <= in_last;
        end else begin
          acc  <= acc_next;
          slot <= slot + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge ps_clk) begin
    if (in_ok && word_done) begin
      out_data <= acc_next;
    end
  end

  // bus must hold a whole number of narrow words
  a_width_ratio: assert property (@(posedge ps_clk)
    (`TTS_BUS_WIDTH % IN_WIDTH) == 0);

endmodule

//--- hw/readout_merge.sv
// Puts the packed timestamp stream, then the packed sample stream, on one bus.
// Only the sample stream's last reaches the output.
`timescale 1ns/1ps

module readout_merge
  import tts_pkg::*;
(
  input  logic      ps_clk,
  input  logic      ps_reset,
  input  logic      flush,
  input  bus_word_t ts_data,
  input  logic      ts_valid,
  input  logic      ts_last,
  output logic      ts_ready,
  input  bus_word_t smp_data,
  input  logic      smp_valid,
  input  logic      smp_last,
  output logic      smp_ready,
  output bus_word_t readout_data,
  output logic      readout_valid,
  output logic      readout_last,
  input  logic      readout_ready
);

  stream_sel_t sel;

  // switch only on an accepted last so the bus stays steady under stall
  always_ff @(posedge ps_clk) begin
    if (ps_reset || flush) begin
      sel <= TIMESTAMP;
    end else begin
      unique case (sel)
        TIMESTAMP: if (ts_valid && ts_ready && ts_last) sel <= SAMPLE;
        SAMPLE: if (smp_valid && smp_ready && smp_last) sel <= TIMESTAMP;
      endcase
    end
  end

  always_comb begin
    if (sel == SAMPLE) begin
      readout_data  = smp_data;
      readout_valid = smp_valid;
      readout_last  = smp_last;
    end else begin
      readout_data  = ts_data;
      readout_valid = ts_valid;
      // timestamps never end the transfer
      readout_last  = 1'b0;
    end
  end

  assign ts_ready  = (sel == TIMESTAMP) && readout_ready;
  assign smp_ready = (sel == SAMPLE) && readout_ready;

endmodule

//--- hw/timetag_buffer_top.sv
// Top level of the time-tagging capture buffer: control, sample and timestamp
// buffers, one packer per buffer and the readout merge.
`timescale 1ns/1ps
`include "tts_cfg.svh"

module timetag_buffer_top
  import tts_pkg::*;
(
  input  logic                                 ps_clk,
  input  logic                                 ps_reset,
  input  logic                                 arm,
  input  logic                                 start,
  input  logic                                 stop,
  input  logic                                 capture_sw_reset,
  input  logic                                 readout_sw_reset,
  input  logic                                 readout_start,
  input  logic                                 digital_trigger,
  input  sample_t                              sample_data,
  input  logic                                 sample_valid,
  input  tstamp_t                              tstamp_data,
  input  logic                                 tstamp_valid,
  output logic                                 discriminator_reset,
  output logic [$clog2(`TTS_SAMPLE_DEPTH):0]   sample_depth,
  output logic [$clog2(`TTS_TSTAMP_DEPTH):0]   tstamp_depth,
  output bus_word_t                            readout_data,
  output logic                                 readout_valid,
  output logic                                 readout_last,
  input  logic                                 readout_ready
);

  logic arm_pulse, hw_start, stop_pulse;
  // bit 1 sample buffer, bit 0 timestamp buffer
  logic [1:0] buffers_ready;
  logic smp_full, ts_full;
  sample_t smp_rd_data;
  logic smp_rd_valid, smp_rd_last, smp_rd_ready;
  tstamp_t ts_rd_data;
  logic ts_rd_valid, ts_rd_last, ts_rd_ready;
  bus_word_t smp_bus_data, ts_bus_data;
  logic smp_bus_valid, smp_bus_last, smp_bus_ready;
  logic ts_bus_valid, ts_bus_last, ts_bus_ready;
  logic readout_flush;

  capture_control u_capture_control (
    .ps_clk, .ps_reset, .arm, .start, .stop, .digital_trigger, .buffers_ready,
    .arm_pulse, .hw_start, .stop_pulse, .discriminator_reset
  );

  ////////////////////////////////////////////////////////////
  // buffers, each stopped by the other one filling up
  ////////////////////////////////////////////////////////////

  capture_buffer #(.payload_t(sample_t), .DEPTH(`TTS_SAMPLE_DEPTH)) u_sample_buffer (
    .ps_clk, .ps_reset, .in_data(sample_data), .in_valid(sample_valid),
    .arm_pulse, .hw_start, .hw_stop(stop_pulse | ts_full),
    .capture_sw_reset, .readout_sw_reset, .readout_start,
    .capture_ready(buffers_ready[1]), .full(smp_full), .write_depth(sample_depth),
    .out_data(smp_rd_data), .out_valid(smp_rd_valid), .out_last(smp_rd_last),
    .out_ready(smp_rd_ready)
  );

  capture_buffer #(.payload_t(tstamp_t), .DEPTH(`TTS_TSTAMP_DEPTH)) u_tstamp_buffer (
    .ps_clk, .ps_reset, .in_data(tstamp_data), .in_valid(tstamp_valid),
    .arm_pulse, .hw_start, .hw_stop(stop_pulse | smp_full),
    .capture_sw_reset, .readout_sw_reset, .readout_start,
    .capture_ready(buffers_ready[0]), .full(ts_full), .write_depth(tstamp_depth),
    .out_data(ts_rd_data), .out_valid(ts_rd_valid), .out_last(ts_rd_last),
    .out_ready(ts_rd_ready)
  );

  // packers and merge clear one cycle behind the buffers
  always_ff @(posedge ps_clk) begin
    if (ps_reset) begin
      readout_flush <= 1'b0;
    end else begin
      readout_flush <= readout_sw_reset;
    end
  end

  width_packer #(.IN_WIDTH(`TTS_SAMPLE_WIDTH)) u_sample_packer (
    .ps_clk, .ps_reset, .flush(readout_flush),
    .in_data(smp_rd_data), .in_valid(smp_rd_valid), .in_last(smp_rd_last),
    .in_ready(smp_rd_ready), .out_data(smp_bus_data), .out_valid(smp_bus_valid),
    .out_last(smp_bus_last), .out_ready(smp_bus_ready)
  );

  width_packer #(.IN_WIDTH(`TTS_TSTAMP_WIDTH)) u_tstamp_packer (
    .ps_clk, .ps_reset, .flush(readout_flush),
    .in_data(ts_rd_data), .in_valid(ts_rd_valid), .in_last(ts_rd_last),
    .in_ready(ts_rd_ready), .out_data(ts_bus_data), .out_valid(ts_bus_valid),
    .out_last(ts_bus_last), .out_ready(ts_bus_ready)
  );

  readout_merge u_readout_merge (
    .ps_clk, .ps_reset, .flush(readout_flush),
    .ts_data(ts_bus_data), .ts_valid(ts_bus_valid), .ts_last(ts_bus_last),
    .ts_ready(ts_bus_ready), .smp_data(smp_bus_data), .smp_valid(smp_bus_valid),
    .smp_last(smp_bus_last), .smp_ready(smp_bus_ready),
    .readout_data, .readout_valid, .readout_last, .readout_ready
  );

endmodule

//--- sim/tb_checker.sv
// Testbench checker: models the capture from the DUT inputs and compares the readout bus.
// Sits beside the DUT in the testbench top and counts every mismatch it finds.
`timescale 1ns/1ps
`include "tts_cfg.svh"

module tb_checker
  import tts_pkg::*;
(
  input  logic                               ps_clk,
  input  logic                               ps_reset,
  input  logic                               arm,
  input  logic                               start,
  input  logic                               stop,
  input  logic                               digital_trigger,
  input  logic                               capture_sw_reset,
  input  logic                               readout_sw_reset,
  input  logic                               readout_start,
  input  sample_t                            sample_data,
  input  logic                               sample_valid,
  input  tstamp_t                            tstamp_data,
  input  logic                               tstamp_valid,
  input  logic                               discriminator_reset,
  input  logic [$clog2(`TTS_SAMPLE_DEPTH):0] sample_depth,
  input  logic [$clog2(`TTS_TSTAMP_DEPTH):0] tstamp_depth,
  input  bus_word_t                          readout_data,
  input  logic                               readout_valid,
  input  logic                               readout_last,
  input  logic                               readout_ready,
  output int                                 error_count
);

  localparam int TW = `TTS_TSTAMP_WIDTH;
  localparam int SW = `TTS_SAMPLE_WIDTH;
  localparam int TR = `TTS_BUS_WIDTH / TW;
  localparam int SR = `TTS_BUS_WIDTH / SW;
  localparam int DL = `TTS_DISC_LATENCY;

  // index 0 timestamp buffer, index 1 sample buffer
  capture_state_t st [2];
  int cnt [2];
  tstamp_t ts_q [$];
  sample_t smp_q [$];
  logic arm_m;
  logic dr;
  logic stop_m;
  logic [DL-1:0] start_dly;
  logic active;
  int idx;
  wire accept = readout_valid && readout_ready;

  function automatic logic holding(input capture_state_t s);
    return (s == HOLD) || (s == READOUT);
  endfunction

  // bus words for n narrow words; an empty buffer still sends one
  function automatic int packed_words(input int n, input int ratio);
    return ((n == 0) ? ratio : n + ratio - 1) / ratio;
  endfunction

  // reference bus word idx: timestamps first, lowest slot first, unused slots zero
  function automatic bus_word_t expected_word(input int idx);
    bus_word_t w;
    int ts_words;
    int base;
    w = '0;
    ts_words = packed_words(ts_q.size(), TR);
    if (idx < ts_words) begin
      for (int k = 0; k < TR; k++) begin
        if (idx * TR + k < ts_q.size()) begin
          w[k*TW +: TW] = ts_q[idx * TR + k];
        end
      end
    end else begin
      base = (idx - ts_words) * SR;
      for (int k = 0; k < SR; k++) begin
        if (base + k < smp_q.size()) begin
          w[k*SW +: SW] = smp_q[base + k];
        end
      end
    end
    return w;
  endfunction

  task automatic note_error(input string msg);
    $display("%s", msg);
    error_count++;
  endtask

  ////////////////////////////////////////////////////////////
  // capture model
  ////////////////////////////////////////////////////////////

  always @(posedge ps_clk) begin
    logic ok;
    logic go;
    logic wr;
    logic [1:0] stop_b;
    int depth;
    ok = !holding(st[0]) && !holding(st[1]);
    go = start_dly[DL-1] || digital_trigger;
    // a full buffer stops the other one
    stop_b[0] = stop_m || (cnt[1] == `TTS_SAMPLE_DEPTH);
    stop_b[1] = stop_m || (cnt[0] == `TTS_TSTAMP_DEPTH);
    if (ps_reset) begin
      arm_m     <= 1'b0;
      dr        <= 1'b0;
      stop_m    <= 1'b0;
      start_dly <= '0;
      for (int b = 0; b < 2; b++) begin
        st[b]  <= IDLE;
        cnt[b] <= 0;
      end
    end else begin
      arm_m     <= arm;
      dr        <= start && ok;
      stop_m    <= stop && ok;
      start_dly <= {start_dly[DL-2:0], dr};
      for (int b = 0; b < 2; b++) begin
        depth = (b == 0) ? `TTS_TSTAMP_DEPTH : `TTS_SAMPLE_DEPTH;
        wr = (st[b] == CAPTURE) && ((b == 0) ? tstamp_valid : sample_valid);
        if (capture_sw_reset) begin
          st[b]  <= IDLE;
          cnt[b] <= 0;
          if (b == 0) begin
            ts_q.delete();
          end else begin
            smp_q.delete();
          end
        end else begin
          if (wr) begin
            cnt[b] <= cnt[b] + 1;
            if (b == 0) begin
              ts_q.push_back(tstamp_data);
            end else begin
              smp_q.push_back(sample_data);
            end
          end
          case (st[b])
            IDLE: begin
              if (arm_m) begin
                st[b]  <= ARMED;
                cnt[b] <= 0;
                if (b == 0) begin
                  ts_q.delete();
                end else begin
                  smp_q.delete();
                end
              end
            end
            ARMED: if (go) st[b] <= CAPTURE;
            CAPTURE: if (stop_b[b] || (wr && cnt[b] == depth - 1)) st[b] <= HOLD;
            HOLD: if (readout_start) st[b] <= READOUT;
            READOUT: begin
              if (readout_sw_reset) begin
                st[b] <= HOLD;
              end else if (accept && readout_last) begin
                st[b] <= IDLE;
              end
            end
            default: st[b] <= IDLE;
          endcase
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // compare
  ////////////////////////////////////////////////////////////

  always @(posedge ps_clk) begin
    int total;
    total = packed_words(ts_q.size(), TR) + packed_words(smp_q.size(), SR);
    if (ps_reset) begin
      active      <= 1'b0;
      idx         <= 0;
      error_count = 0;
    end else begin
      if (sample_depth != cnt[1]) begin
        note_error($sformatf("FAILED at %0t: sample depth %0d in %s, expected %0d",
                             $time, sample_depth, st[1].name(), cnt[1]));
      end
      if (tstamp_depth != cnt[0]) begin
        note_error($sformatf("FAILED at %0t: timestamp depth %0d in %s, expected %0d",
                             $time, tstamp_depth, st[0].name(), cnt[0]));
      end
      if (discriminator_reset !== dr) begin
        note_error($sformatf("FAILED at %0t: discriminator_reset is %b, expected %b",
                             $time, discriminator_reset, dr));
      end
      if (readout_sw_reset) begin
        active <= 1'b0;
      end else if (readout_start && st[0] == HOLD && st[1] == HOLD) begin
        active <= 1'b1;
        idx    <= 0;
      end
      if (accept) begin
        if (!active) begin
          note_error($sformatf("a readout word was taken at %0t with no transfer running",
                               $time));
        end else if (idx >= total) begin
          note_error($sformatf("the readout ran past its %0d words at %0t", total, $time));
        end else begin
          if (readout_data !== expected_word(idx)) begin
            note_error($sformatf("FAILED at %0t: word %0d is %h, expected %h",
                                 $time, idx, readout_data, expected_word(idx)));
          end
          if (readout_last !== (idx == total - 1)) begin
            note_error($sformatf("FAILED at %0t: last is %b on word %0d of %0d",
                                 $time, readout_last, idx, total));
          end
          if (readout_last) begin
            active <= 1'b0;
          end
          idx <= idx + 1;
        end
      end
    end
  end

endmodule

//--- sim/tb_timetag_buffer.sv
// Testbench top for the time-tagging capture buffer: clock, reset, stimulus and tests.
// The checker instance compares the readout; this module drives and reports.
`timescale 1ns/1ps
`include "tts_cfg.svh"

module tb_timetag_buffer
  import tts_pkg::*;
();

  localparam int TESTS = 6;
  // one capture and one slow readout per test, plus the repeated readout
  localparam int CYCLE_LIMIT = (TESTS + 1) *
    (`TTS_SAMPLE_DEPTH + 40 + 4 * (`TTS_SAMPLE_DEPTH + `TTS_TSTAMP_DEPTH));

  logic ps_clk;
  logic ps_reset;
  logic arm;
  logic start;
  logic stop;
  logic digital_trigger;
  logic capture_sw_reset;
  logic readout_sw_reset;
  logic readout_start;
  sample_t sample_data;
  logic sample_valid;
  tstamp_t tstamp_data;
  logic tstamp_valid;
  logic discriminator_reset;
  logic [$clog2(`TTS_SAMPLE_DEPTH):0] sample_depth;
  logic [$clog2(`TTS_TSTAMP_DEPTH):0] tstamp_depth;
  bus_word_t readout_data;
  logic readout_valid;
  logic readout_last;
  logic readout_ready;
  int error_count;

  logic [31:0] lfsr;
  logic feed_on;
  logic smp_every_cycle;
  // 0 ready high, 1 random, 2 ready low
  int ready_mode;
  int cycles = 0;
  int tests_failed;
  int errors_before;

  timetag_buffer_top u_timetag_buffer_top (.*);
  tb_checker u_checker (.*);

  always #4 ps_clk = ~ps_clk;

  always @(posedge ps_clk) begin
    cycles <= cycles + 1;
    if (cycles == CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Test failures found");
      $finish;
    end
  end

  // galois lfsr, one step per bit taken
  function automatic logic [63:0] random_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      r[i] = lfsr[0];
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////

  // one cycle: clear pulses, new payloads, valid gaps and ready
  task automatic tick();
    @(posedge ps_clk);
    #1;
    arm              = 1'b0;
    start            = 1'b0;
    stop             = 1'b0;
    digital_trigger  = 1'b0;
    capture_sw_reset = 1'b0;
    readout_sw_reset = 1'b0;
    readout_start    = 1'b0;
    sample_data      = random_bits(64);
    tstamp_data      = tstamp_t'(random_bits(32));
    sample_valid     = feed_on && (smp_every_cycle || random_bits(1) != '0);
    tstamp_valid     = feed_on && (random_bits(2) == 64'd3);
    readout_ready    = (ready_mode == 0) || (ready_mode == 1 && random_bits(1) != '0);
  endtask

  task automatic arm_buffers();
    tick();
    arm = 1'b1;
    repeat (3) tick();
  endtask

  // start the readout and return once the word with last has been taken
  task automatic read_all();
    tick();
    readout_start = 1'b1;
    do begin
      tick();
    end while (!(readout_valid && readout_ready && readout_last));
    tick();
  endtask

  task automatic end_test(input int num, input string name);
    if (error_count == errors_before) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: %0d errors", num, name, error_count - errors_before);
      tests_failed++;
    end
    errors_before = error_count;
  endtask

  initial begin
    ps_clk           = 1'b0;
    ps_reset         = 1'b1;
    arm              = 1'b0;
    start            = 1'b0;
    stop             = 1'b0;
    digital_trigger  = 1'b0;
    capture_sw_reset = 1'b0;
    readout_sw_reset = 1'b0;
    readout_start    = 1'b0;
    sample_data      = '0;
    sample_valid     = 1'b0;
    tstamp_data      = '0;
    tstamp_valid     = 1'b0;
    readout_ready    = 1'b1;
    lfsr             = 32'h2841_8073;
    feed_on          = 1'b0;
    smp_every_cycle  = 1'b0;
    ready_mode       = 0;
    tests_failed     = 0;
    errors_before    = 0;
    repeat (5) @(posedge ps_clk);
    #1;
    ps_reset = 1'b0;

    // sample buffer fills and stops the timestamp buffer
    smp_every_cycle = 1'b1;
    feed_on = 1'b1;
    arm_buffers();
    tick();
    start = 1'b1;
    do begin
      tick();
    end while (sample_depth != `TTS_SAMPLE_DEPTH);
    feed_on = 1'b0;
    repeat (4) tick();
    read_all();
    end_test(1, "full stop");

    // external stop with gaps on both inputs
    smp_every_cycle = 1'b0;
    feed_on = 1'b1;
    arm_buffers();
    tick();
    start = 1'b1;
    repeat (20) tick();
    stop = 1'b1;
    repeat (3) tick();
    feed_on = 1'b0;
    repeat (2) tick();
    read_all();
    end_test(2, "external stop");

    // trigger only; words fed while armed must not be stored
    feed_on = 1'b1;
    arm_buffers();
    repeat (6) tick();
    tick();
    digital_trigger = 1'b1;
    repeat (12) tick();
    stop = 1'b1;
    repeat (3) tick();
    feed_on = 1'b0;
    repeat (2) tick();
    read_all();
    end_test(3, "digital trigger");

    // random readout back-pressure
    feed_on = 1'b1;
    arm_buffers();
    tick();
    start = 1'b1;
    repeat (24) tick();
    stop = 1'b1;
    repeat (3) tick();
    feed_on = 1'b0;
    ready_mode = 1;
    read_all();
    ready_mode = 0;
    end_test(4, "back-pressure");

    // capture reset mid-capture, then an empty capture
    feed_on = 1'b1;
    arm_buffers();
    tick();
    start = 1'b1;
    repeat (15) tick();
    capture_sw_reset = 1'b1;
    feed_on = 1'b0;
    arm_buffers();
    tick();
    digital_trigger = 1'b1;
    repeat (3) tick();
    stop = 1'b1;
    repeat (3) tick();
    read_all();
    end_test(5, "capture reset");

    // readout reset mid-transfer, then a full readout
    feed_on = 1'b1;
    arm_buffers();
    tick();
    start = 1'b1;
    // enough timestamps that their readout is still running at the abort
    do begin
      tick();
    end while (tstamp_depth < 10);
    stop = 1'b1;
    repeat (3) tick();
    feed_on = 1'b0;
    tick();
    readout_start = 1'b1;
    do begin
      tick();
    end while (!(readout_valid && readout_ready));
    repeat (2) tick();
    ready_mode = 2;
    tick();
    readout_sw_reset = 1'b1;
    repeat (3) tick();
    ready_mode = 0;
    read_all();
    end_test(6, "readout reset");

    $display("%0d tests run, %0d failed, %0d errors", TESTS, tests_failed, error_count);
    if (tests_failed == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- timetag_buffer_top.f
+incdir+hw
hw/tts_pkg.sv
hw/capture_control.sv
hw/capture_buffer.sv
hw/width_packer.sv
hw/readout_merge.sv
hw/timetag_buffer_top.sv
sim/tb_checker.sv
sim/tb_timetag_buffer.sv

//--- Bender.yml
package:
  name: timetag_buffer

sources:
  - include_dirs:
      - hw
    files:
      - hw/tts_pkg.sv
      - hw/capture_control.sv
      - hw/capture_buffer.sv
      - hw/width_packer.sv
      - hw/readout_merge.sv
      - hw/timetag_buffer_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/tb_checker.sv
      - sim/tb_timetag_buffer.sv
